// File: rtl/drp_pkg.sv
package drp_pkg;

	////////////////////
	// APB side types

	// Byte address width of the register window
	localparam int apb_addr_width = 8;

	// Full APB data word
	typedef logic [31:0] apb_data_t;

	// Native DRP data word
	typedef logic [15:0] drp_data_t;

	////////////////////
	// Register map

	typedef enum logic [apb_addr_width-1:0] {
		// DRP address in the low bits and write select in bit 15
		REG_ADDR     = 8'h00,
		// Write data before launch and read data after a read
		REG_DATA     = 8'h04,
		// Bit 0 busy and bit 1 RX reset done
		REG_STATUS   = 8'h08,
		// Same content as REG_STATUS
		REG_STATUS_2 = 8'h28
	} reg_addr_t;

	////////////////////
	// Port master FSM

	typedef enum logic [1:0] {
		// Waiting for a start pulse
		DRP_IDLE,
		// Strobe issued, waiting for ready
		DRP_WAIT_RDY,
		// One cycle to report completion
		DRP_RESPOND
	} drp_state_t;

endpackage

// File: rtl/apb_if.sv
`timescale 1ns/10ps

interface apb_if import drp_pkg::*; ();

	////////////////////
	// Request side

	// Select and access phase strobes
	logic                      psel;
	logic                      penable;
	logic                      pwrite;

	// Byte address inside the register window
	logic [apb_addr_width-1:0] paddr;
	apb_data_t                 pwdata;

	////////////////////
	// Response side

	apb_data_t                 prdata;
	// Always ready in the access cycle
	logic                      pready;
	logic                      pslverr;

	// Register block end of the bus
	modport completer (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready,
		output pslverr
	);

endinterface

// File: rtl/drp_mgmt_if.sv
`timescale 1ns/10ps

interface drp_mgmt_if import drp_pkg::*; #(
	parameter int drp_addr_width = 9
) ();

	// Launch pulse, one apb cycle
	logic                      en;
	// Request fields, held until done
	logic                      wr;
	logic [drp_addr_width-1:0] addr;
	drp_data_t                 wdata;

	// Response from the drp_clk side
	drp_data_t                 rdata;
	// Completion pulse, one apb cycle
	logic                      done;

	// Register block side
	modport regs (
		output en,
		output wr,
		output addr,
		output wdata,
		input  rdata,
		input  done
	);

	// Crossing side
	modport cdc (
		input  en,
		output rdata,
		output done
	);

endinterface

// File: rtl/drp_apb_regs.sv
`timescale 1ns/10ps

module drp_apb_regs import drp_pkg::*; #(
	parameter int drp_addr_width = 9
) (
	input  logic     apb,
	input  logic     rst_n,
	apb_if.completer bus,
	drp_mgmt_if.regs mgmt,
	input  logic     rx_rst_done
);

	logic      access;
	logic      wr_access;
	logic      rd_access;
	logic      free;
	logic      launch;
	logic      busy;
	logic      rx_meta;
	logic      rx_sync;
	drp_data_t data_q;
	drp_data_t rd_q;

	////////////////////
	// Access decode

	// No wait states, every access phase completes at once
	assign access    = bus.psel & bus.penable;
	assign wr_access = access & bus.pwrite;
	assign rd_access = access & ~bus.pwrite;
	assign bus.pready = access;

	// Launch cycle counts as busy too
	assign free = ~(busy | mgmt.en);

	// Accepted REG_ADDR write starts an operation
	assign launch = wr_access & (bus.paddr == REG_ADDR) & free;

	////////////////////
	// Read data and error response

	always_comb begin
		bus.prdata  = '0;
		bus.pslverr = 1'b0;
		if (wr_access) begin
			case (bus.paddr)
				// Refused while an operation is in flight
				REG_ADDR: bus.pslverr = ~free;
				REG_DATA: bus.pslverr = 1'b0;
				// Status is read only, rest unmapped
				default:  bus.pslverr = 1'b1;
			endcase
		end else if (rd_access) begin
			case (bus.paddr)
				REG_DATA: bus.prdata = {16'h0, rd_q};
				REG_STATUS, REG_STATUS_2: begin
					bus.prdata = {30'h0, rx_sync, busy};
				end
				// No readback of REG_ADDR
				default:  bus.pslverr = 1'b1;
			endcase
		end
	end

	////////////////////
	// Control state

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			mgmt.en <= 1'b0;
			busy    <= 1'b0;
			rx_meta <= 1'b0;
			rx_sync <= 1'b0;
		end else begin
			// One cycle launch strobe
			mgmt.en <= launch;

			// Busy from the edge after en until the edge after done
			if (mgmt.en) begin
				busy <= 1'b1;
			end else if (mgmt.done) begin
				busy <= 1'b0;
			end

			// RX reset done from the transceiver domain
			rx_meta <= rx_rst_done;
			rx_sync <= rx_meta;
		end
	end

	////////////////////
	// Data registers

	always_ff @(posedge apb) begin
		// Staging word, copied into the request at launch
		if (wr_access && bus.paddr == REG_DATA) begin
			data_q <= bus.pwdata[15:0];
		end

		// Request fields stay put until the next launch
		if (launch) begin
			mgmt.wr    <= bus.pwdata[15];
			mgmt.addr  <= bus.pwdata[drp_addr_width-1:0];
			mgmt.wdata <= data_q;
		end

		// Keep only read results
		if (mgmt.done && !mgmt.wr) begin
			rd_q <= mgmt.rdata;
		end
	end

endmodule

// File: rtl/drp_cdc.sv
`timescale 1ns/10ps

module drp_cdc import drp_pkg::*; #(
	parameter int drp_addr_width = 9
) (
	input  logic      apb,
	input  logic      rst_n,
	input  logic      drp_clk,
	drp_mgmt_if.cdc   mgmt,
	output logic      start,
	output logic      drp_rst_n,
	input  logic      finish,
	input  drp_data_t rd_word
);

	// 9 bit and 10 bit DRP address maps only
	if (drp_addr_width < 9 || drp_addr_width > 10) begin : g_width_check
		$error("drp_cdc: unsupported DRP address width %0d", drp_addr_width);
	end

	logic       drp_rst_meta;
	logic       req_tgl;
	// Two sync flops plus one history flop
	logic [2:0] req_sync;
	logic       rsp_tgl;
	drp_data_t  rsp_data;
	logic [2:0] rsp_sync;

	////////////////////
	// Reset into drp_clk

	always_ff @(posedge drp_clk) begin
		drp_rst_meta <= rst_n;
		drp_rst_n    <= drp_rst_meta;
	end

	////////////////////
	// Request path

	// Flip once per launch
	always_ff @(posedge apb) begin
		if (!rst_n) begin
			req_tgl <= 1'b0;
		end else if (mgmt.en) begin
			req_tgl <= ~req_tgl;
		end
	end

	always_ff @(posedge drp_clk) begin
		if (!drp_rst_n) begin
			req_sync <= '0;
		end else begin
			req_sync <= {req_sync[1:0], req_tgl};
		end
	end

	// Either edge of the toggle is a new request
	assign start = req_sync[2] ^ req_sync[1];

	////////////////////
	// Response path

	always_ff @(posedge drp_clk) begin
		if (!drp_rst_n) begin
			rsp_tgl <= 1'b0;
		end else if (finish) begin
			rsp_tgl <= ~rsp_tgl;
		end
	end

	// Captured with the toggle, stable long before apb sees it
	always_ff @(posedge drp_clk) begin
		if (finish) begin
			rsp_data <= rd_word;
		end
	end

	assign mgmt.rdata = rsp_data;

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			rsp_sync <= '0;
		end else begin
			rsp_sync <= {rsp_sync[1:0], rsp_tgl};
		end
	end

	// Completion pulse in the apb domain
	assign mgmt.done = rsp_sync[2] ^ rsp_sync[1];

endmodule

// File: rtl/drp_port_master.sv
`timescale 1ns/10ps

module drp_port_master import drp_pkg::*; #(
	parameter int drp_addr_width = 9
) (
	input  logic                      drp_clk,
	input  logic                      drp_rst_n,
	input  logic                      start,
	input  logic                      wr,
	input  logic [drp_addr_width-1:0] addr,
	input  drp_data_t                 wdata,
	output logic                      finish,
	output drp_data_t                 rd_word,
	output logic                      drp_en,
	output logic                      drp_we,
	output logic [drp_addr_width-1:0] drp_addr,
	output drp_data_t                 drp_wdata,
	input  logic                      drp_rdy,
	input  drp_data_t                 drp_rdata
);

	drp_state_t state;

	////////////////////
	// Strobe FSM

	always_ff @(posedge drp_clk) begin
		if (!drp_rst_n) begin
			state  <= DRP_IDLE;
			drp_en <= 1'b0;
			drp_we <= 1'b0;
		end else begin
			// Strobe lasts one cycle
			drp_en <= 1'b0;
			case (state)
				DRP_IDLE: begin
					if (start) begin
						drp_en <= 1'b1;
						drp_we <= wr;
						state  <= DRP_WAIT_RDY;
					end
				end
				DRP_WAIT_RDY: begin
					// Write enable only alongside the strobe
					drp_we <= 1'b0;
					if (drp_rdy) begin
						state <= DRP_RESPOND;
					end
				end
				DRP_RESPOND: state <= DRP_IDLE;
				default:     state <= DRP_IDLE;
			endcase
		end
	end

	////////////////////
	// Payload

	always_ff @(posedge drp_clk) begin
		// Address and data valid with the strobe
		if (state == DRP_IDLE && start) begin
			drp_addr  <= addr;
			drp_wdata <= wdata;
		end
		// Read data only valid on ready
		if (state == DRP_WAIT_RDY && drp_rdy) begin
			rd_word <= drp_rdata;
		end
	end

	// Completion for the response toggle
	assign finish = (state == DRP_RESPOND);

endmodule

// File: rtl/serdes_drp_bridge.sv
`timescale 1ns/10ps

module serdes_drp_bridge import drp_pkg::*; #(
	parameter int drp_addr_width = 9
) (
	input  logic                      apb,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [apb_addr_width-1:0] paddr,
	input  apb_data_t                 pwdata,
	output apb_data_t                 prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      drp_clk,
	output logic                      drp_en,
	output logic                      drp_we,
	output logic [drp_addr_width-1:0] drp_addr,
	output drp_data_t                 drp_wdata,
	input  drp_data_t                 drp_rdata,
	input  logic                      drp_rdy,
	input  logic                      rx_rst_done
);

	logic      start;
	logic      finish;
	logic      drp_rst_n;
	drp_data_t rd_word;

	////////////////////
	// Bus bundles

	apb_if apb_bus ();

	drp_mgmt_if #(
		.drp_addr_width(drp_addr_width)
	) mgmt_bus ();

	// Plain APB ports onto the bundle
	assign apb_bus.psel    = psel;
	assign apb_bus.penable = penable;
	assign apb_bus.pwrite  = pwrite;
	assign apb_bus.paddr   = paddr;
	assign apb_bus.pwdata  = pwdata;
	assign prdata  = apb_bus.prdata;
	assign pready  = apb_bus.pready;
	assign pslverr = apb_bus.pslverr;

	////////////////////
	// Blocks

	drp_apb_regs #(
		.drp_addr_width(drp_addr_width)
	) u_regs (
		.apb        (apb),
		.rst_n      (rst_n),
		.bus        (apb_bus),
		.mgmt       (mgmt_bus),
		.rx_rst_done(rx_rst_done)
	);

	drp_cdc #(
		.drp_addr_width(drp_addr_width)
	) u_cdc (
		.apb      (apb),
		.rst_n    (rst_n),
		.drp_clk  (drp_clk),
		.mgmt     (mgmt_bus),
		.start    (start),
		.drp_rst_n(drp_rst_n),
		.finish   (finish),
		.rd_word  (rd_word)
	);

	// Request fields are quasi static across the crossing
	drp_port_master #(
		.drp_addr_width(drp_addr_width)
	) u_master (
		.drp_clk  (drp_clk),
		.drp_rst_n(drp_rst_n),
		.start    (start),
		.wr       (mgmt_bus.wr),
		.addr     (mgmt_bus.addr),
		.wdata    (mgmt_bus.wdata),
		.finish   (finish),
		.rd_word  (rd_word),
		.drp_en   (drp_en),
		.drp_we   (drp_we),
		.drp_addr (drp_addr),
		.drp_wdata(drp_wdata),
		.drp_rdy  (drp_rdy),
		.drp_rdata(drp_rdata)
	);

endmodule

// File: verif/drp_target_model.sv
`timescale 1ns/10ps

module drp_target_model import drp_pkg::*; #(
	parameter int addr_width = 9
) (
	input  logic                  drp_clk,
	input  logic                  drp_en,
	input  logic                  drp_we,
	input  logic [addr_width-1:0] drp_addr,
	input  drp_data_t             drp_wdata,
	output drp_data_t             drp_rdata,
	output logic                  drp_rdy
);

	// Register space of the modeled transceiver
	drp_data_t             mem [0:(1<<addr_width)-1];
	logic [addr_width-1:0] addr_q;
	logic [31:0]           rnd;
	logic                  pending;
	int                    wait_cnt;
	// Strobes seen since time zero
	int                    strobe_count;
	// Set on a strobe while a transfer is still open
	logic                  overlap;

	////////////////////
	// Power up contents

	initial begin
		// Preload is the address XOR a fixed pattern
		for (int i = 0; i < (1 << addr_width); i++) begin
			mem[i] = drp_data_t'(i) ^ 16'hA5A5;
		end
		drp_rdata    = '0;
		drp_rdy      = 1'b0;
		pending      = 1'b0;
		wait_cnt     = 0;
		strobe_count = 0;
		overlap      = 1'b0;
	end

	////////////////////
	// Strobe and ready

	always @(posedge drp_clk) begin
		// Ready is a single cycle pulse
		drp_rdy <= 1'b0;
		if (drp_en) begin
			if (pending) begin
				overlap <= 1'b1;
			end
			strobe_count <= strobe_count + 1;
			addr_q       <= drp_addr;
			if (drp_we) begin
				mem[drp_addr] <= drp_wdata;
			end
			// Ready after 1 to 8 cycles
			rnd      = $urandom;
			wait_cnt <= 1 + int'(rnd[2:0]);
			pending  <= 1'b1;
		end else if (pending) begin
			if (wait_cnt == 1) begin
				drp_rdy   <= 1'b1;
				drp_rdata <= mem[addr_q];
				pending   <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

endmodule

// File: verif/serdes_drp_tb.sv
`timescale 1ns/10ps

module serdes_drp_tb import drp_pkg::*; ();

	localparam int drp_addr_width = 9;
	// Bounded status polls per operation
	localparam int max_polls = 40;
	// Launches over all tests
	localparam int num_ops = 43;
	// Twice 8 drp_clk periods per op plus about 10 APB transfers of polling
	localparam int timeout_ns = 2 * (num_ops * 8 * 70 + num_ops * 10 * 3 * 100);
	// Random traffic folds onto 32 addresses so reads hit earlier writes
	localparam logic [drp_addr_width-1:0] traffic_mask = 9'h10F;

	logic                      apb;
	logic                      drp_clk;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [apb_addr_width-1:0] paddr;
	apb_data_t                 pwdata;
	apb_data_t                 prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      drp_en;
	logic                      drp_we;
	logic [drp_addr_width-1:0] drp_addr;
	drp_data_t                 drp_wdata;
	drp_data_t                 drp_rdata;
	logic                      drp_rdy;
	logic                      rx_rst_done;
	// Expected DRP contents
	drp_data_t                 ref_mem [0:(1<<drp_addr_width)-1];

	////////////////////
	// Clocks, DUT, target

	always #50 apb = ~apb;
	// Unrelated to apb
	always #35 drp_clk = ~drp_clk;

	serdes_drp_bridge #(
		.drp_addr_width(drp_addr_width)
	) u_dut (
		.apb(apb), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .drp_clk(drp_clk), .drp_en(drp_en), .drp_we(drp_we),
		.drp_addr(drp_addr), .drp_wdata(drp_wdata), .drp_rdata(drp_rdata),
		.drp_rdy(drp_rdy), .rx_rst_done(rx_rst_done)
	);

	drp_target_model #(
		.addr_width(drp_addr_width)
	) u_model (
		.drp_clk(drp_clk), .drp_en(drp_en), .drp_we(drp_we), .drp_addr(drp_addr),
		.drp_wdata(drp_wdata), .drp_rdata(drp_rdata), .drp_rdy(drp_rdy)
	);

	////////////////////
	// Failure and compare

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input drp_data_t exp, input drp_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s expected 0x%04h got 0x%04h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_slverr(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, exp, act));
		end
	endtask

	////////////////////
	// APB access

	// Setup, access and idle cycles with the response sampled mid access
	task automatic apb_transfer(input logic wr, input logic [apb_addr_width-1:0] addr,
		input apb_data_t wdata, output apb_data_t rdata, output logic err);
		@(posedge apb);
		#10;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge apb);
		#10;
		penable = 1'b1;
		@(negedge apb);
		if (pready !== 1'b1) begin
			abort_run("pready was low in the APB access phase");
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge apb);
		#10;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [apb_addr_width-1:0] addr, input apb_data_t data,
		output logic err);
		apb_data_t unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [apb_addr_width-1:0] addr, output apb_data_t data,
		output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	// REG_ADDR word with write select in bit 15
	function automatic apb_data_t launch_word(input logic wr,
		input logic [drp_addr_width-1:0] addr);
		apb_data_t word;
		word     = apb_data_t'(addr);
		word[15] = wr;
		return word;
	endfunction

	task automatic read_status(input logic [apb_addr_width-1:0] addr, output logic [1:0] st);
		apb_data_t rdata;
		logic      err;
		apb_read(addr, rdata, err);
		check_slverr("pslverr on status read", 1'b0, err);
		st = rdata[1:0];
	endtask

	// Poll busy and compare the mirror once idle
	task automatic wait_idle();
		logic [1:0] st;
		logic [1:0] st2;
		int         polls;
		polls = 0;
		read_status(REG_STATUS, st);
		while (st[0] && polls < max_polls) begin
			polls++;
			read_status(REG_STATUS, st);
		end
		if (st[0]) begin
			abort_run("busy did not clear within the poll limit");
		end else begin
			read_status(REG_STATUS_2, st2);
			check_status("REG_STATUS_2", st, st2);
		end
	endtask

	// One full DRP operation through the register window
	task automatic run_op(input logic wr, input logic [drp_addr_width-1:0] addr,
		input drp_data_t data, output drp_data_t rd);
		apb_data_t rdata;
		logic      err;
		apb_write(REG_DATA, apb_data_t'(data), err);
		check_slverr("pslverr on REG_DATA write", 1'b0, err);
		apb_write(REG_ADDR, launch_word(wr, addr), err);
		check_slverr("pslverr on REG_ADDR write", 1'b0, err);
		wait_idle();
		rd = '0;
		if (!wr) begin
			apb_read(REG_DATA, rdata, err);
			check_slverr("pslverr on REG_DATA read", 1'b0, err);
			rd = rdata[15:0];
		end
	endtask

	////////////////////
	// Directed tests

	task automatic test_reset();
		logic [1:0] st;
		read_status(REG_STATUS, st);
		check_status("REG_STATUS", 2'b00, st);
		if (u_model.strobe_count != 0) begin
			abort_run("drp_en pulsed before any operation was launched");
		end
	endtask

	task automatic test_write_read();
		drp_data_t rd;
		run_op(1'b1, 9'h05A, 16'hC3E1, rd);
		ref_mem[9'h05A] = 16'hC3E1;
		run_op(1'b0, 9'h05A, 16'h0000, rd);
		check_data("REG_DATA", 16'hC3E1, rd);
		check_data("model mem[0x05A]", 16'hC3E1, u_model.mem[9'h05A]);
	endtask

	task automatic test_random_traffic();
		logic [31:0]               rnd;
		logic [drp_addr_width-1:0] addr;
		drp_data_t                 data;
		drp_data_t                 rd;
		logic                      wr;
		for (int n = 0; n < 40; n++) begin
			rnd  = $urandom;
			addr = rnd[drp_addr_width-1:0] & traffic_mask;
			wr   = rnd[31];
			rnd  = $urandom;
			data = rnd[15:0];
			run_op(wr, addr, data, rd);
			if (wr) begin
				ref_mem[addr] = data;
			end else begin
				check_data($sformatf("REG_DATA for 0x%03h", addr), ref_mem[addr], rd);
			end
		end
	endtask

	task automatic test_error_responses();
		apb_data_t rdata;
		logic      err;
		int        strobes;
		apb_read(8'h10, rdata, err);
		check_slverr("pslverr on unmapped read", 1'b1, err);
		apb_read(REG_ADDR, rdata, err);
		check_slverr("pslverr on REG_ADDR read", 1'b1, err);
		apb_write(REG_STATUS, 32'h3, err);
		check_slverr("pslverr on REG_STATUS write", 1'b1, err);
		// Second launch lands while the first is still in flight
		strobes = u_model.strobe_count;
		apb_write(REG_DATA, 32'h1234, err);
		check_slverr("pslverr on REG_DATA write", 1'b0, err);
		apb_write(REG_ADDR, launch_word(1'b1, 9'h0C3), err);
		check_slverr("pslverr on REG_ADDR write", 1'b0, err);
		apb_write(REG_DATA, 32'hBEEF, err);
		check_slverr("pslverr on REG_DATA write while busy", 1'b0, err);
		apb_write(REG_ADDR, launch_word(1'b1, 9'h13C), err);
		check_slverr("pslverr on REG_ADDR write while busy", 1'b1, err);
		wait_idle();
		ref_mem[9'h0C3] = 16'h1234;
		check_data("model mem[0x0C3]", 16'h1234, u_model.mem[9'h0C3]);
		check_data("model mem[0x13C]", ref_mem[9'h13C], u_model.mem[9'h13C]);
		if (u_model.strobe_count != strobes + 1) begin
			abort_run("refused REG_ADDR write still reached the DRP port");
		end
	endtask

	task automatic test_status_mirror();
		logic [1:0] st;
		logic [1:0] st2;
		int         polls;
		read_status(REG_STATUS, st);
		read_status(REG_STATUS_2, st2);
		check_status("REG_STATUS_2", st, st2);
		check_status("REG_STATUS", 2'b00, st);
		@(posedge apb);
		#10;
		rx_rst_done = 1'b1;
		// Two flop sync needs only a few polls
		polls = 0;
		read_status(REG_STATUS, st);
		while (!st[1] && polls < 8) begin
			polls++;
			read_status(REG_STATUS, st);
		end
		check_status("REG_STATUS", 2'b10, st);
		read_status(REG_STATUS_2, st2);
		check_status("REG_STATUS_2", st, st2);
	endtask

	////////////////////
	// Run control

	initial begin
		#(timeout_ns);
		abort_run("watchdog timeout, tests did not finish in time");
	end

	initial begin
		void'($urandom(15));
		apb         = 1'b0;
		drp_clk     = 1'b0;
		rst_n       = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		rx_rst_done = 1'b0;
		for (int i = 0; i < (1 << drp_addr_width); i++) begin
			ref_mem[i] = drp_data_t'(i) ^ 16'hA5A5;
		end
		repeat (5) @(posedge apb);
		#10;
		rst_n = 1'b1;
		// Let the drp_clk reset sync release
		repeat (4) @(posedge apb);
		test_reset();
		test_write_read();
		test_random_traffic();
		test_error_responses();
		test_status_mirror();
		if (u_model.overlap) begin
			abort_run("DRP strobe issued while a transfer was still open");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// File: flist.f
rtl/drp_pkg.sv
rtl/apb_if.sv
rtl/drp_mgmt_if.sv
rtl/drp_apb_regs.sv
rtl/drp_cdc.sv
rtl/drp_port_master.sv
rtl/serdes_drp_bridge.sv
verif/drp_target_model.sv
verif/serdes_drp_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DRP bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module serdes_drp_tb -o serdes_drp_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/serdes_drp_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
echo "pass message not found"
exit 1
